/* verilog/rv_insn_pkg.sv */
package rv_insn_pkg;

  // Major opcodes that differ only in bit 3
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;

  localparam logic [2:0] F3_ADD     = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Upper shift field in bits 31:26
  localparam logic [5:0] F6_SRL = 6'b000000;
  localparam logic [5:0] F6_SRA = 6'b010000;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } insn_itype_t;

  typedef struct packed {
    logic [5:0] funct6;
    logic [5:0] shamt6;  // Top bit is insn bit 25
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_shift_t;

  typedef union packed {
    insn_itype_t itype;
    insn_shift_t shift;
  } insn_word_u;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_ADD,
    OP_SLT,
    OP_SLTU,
    OP_XOR,
    OP_OR,
    OP_AND,
    OP_SLL,
    OP_SRL,
    OP_SRA
  } opimm_op_e;

endpackage

/* verilog/core_ctl_pkg.sv */
package core_ctl_pkg;

  typedef enum logic [1:0] {
    PH_OPERAND  = 2'd0,  // Immediate select or trap entry
    PH_READ     = 2'd1,  // Source read, low half fetch
    PH_EXEC     = 2'd2,  // ALU and writeback
    PH_FETCH_HI = 2'd3   // High half fetch, PC advance
  } phase_e;

  typedef struct packed {
    logic adr_npc;
    logic adr_npc_plus2;
    logic size_2;
    logic vpa;
    logic we;
    logic irl_dat;
    logic irh_dat;
    logic ir_dat_irl;
    logic cpc_npc;
    logic npc_npc_plus4;
  } fetch_ctl_t;

  typedef struct packed {
    logic adr_mtvec;
    logic npc_mtvec;
    logic mepc_npc;
    logic mepc_cpc;
    logic mpie_mie;
    logic mie_0;
    logic mcause_we;
  } trap_ctl_t;

  typedef struct packed {
    logic sum_en;
    logic and_en;
    logic xor_en;
    logic invb_en;
    logic lsh_en;
    logic rsh_en;
    logic ltu_en;
    logic lts_en;
    logic cflag_1;
    logic sx32_en;
  } alu_ctl_t;

  typedef struct packed {
    logic       alub_imm6i;
    logic       alub_imm12;
    logic       ra_ir1;
    logic       ra_ird;
    logic       alua_rf;
    logic       rf_alu;
    logic [3:0] rmask;
  } reg_ctl_t;

endpackage

/* verilog/opimm_field_decoder.sv */
`timescale 1ns/1ns

module opimm_field_decoder #(
  parameter bit RV64 = 1'b1
) (
  input  rv_insn_pkg::insn_word_u insn_i,
  output rv_insn_pkg::opimm_op_e  op_o,
  output logic                    word_form_o,
  output logic                    defined_o
);
  import rv_insn_pkg::*;

  opimm_op_e op_raw;
  logic      word_form;
  logic      opc_ok;
  logic      form_ok;
  logic      is_shift;
  logic      shamt_ok;

  assign word_form = insn_i.itype.opcode[3];
  assign opc_ok    = (insn_i.itype.opcode == OPC_OP_IMM) ||
                     (insn_i.itype.opcode == OPC_OP_IMM_32);
  assign form_ok   = !word_form || RV64;  // No word forms on RV32

  assign is_shift  = (insn_i.itype.funct3 == F3_SLL) ||
                     (insn_i.itype.funct3 == F3_SRL_SRA);

  // Bit 25 only legal for full width shifts on RV64
  assign shamt_ok  = !is_shift || !insn_i.shift.shamt6[5] || (RV64 && !word_form);

  always_comb begin
    op_raw = OP_NONE;
    case (insn_i.itype.funct3)
      F3_ADD:  op_raw = OP_ADD;
      F3_SLT:  op_raw = OP_SLT;
      F3_SLTU: op_raw = OP_SLTU;
      F3_XOR:  op_raw = OP_XOR;
      F3_OR:   op_raw = OP_OR;
      F3_AND:  op_raw = OP_AND;
      F3_SLL: begin
        if (insn_i.shift.funct6 == F6_SRL) begin
          op_raw = OP_SLL;
        end
      end
      F3_SRL_SRA: begin
        case (insn_i.shift.funct6)
          F6_SRL:  op_raw = OP_SRL;
          F6_SRA:  op_raw = OP_SRA;
          default: op_raw = OP_NONE;  // Bad funct6
        endcase
      end
    endcase
  end

  assign defined_o   = opc_ok && form_ok && shamt_ok && (op_raw != OP_NONE);
  assign op_o        = defined_o ? op_raw : OP_NONE;
  assign word_form_o = word_form;

endmodule

/* verilog/opimm_sequencer.sv */
`timescale 1ns/1ns

module opimm_sequencer (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    defined_i,
  input  logic                    trap_i,
  input  logic                    ack_i,
  output core_ctl_pkg::phase_e     phase_o,
  output core_ctl_pkg::fetch_ctl_t fetch_ctl_o,
  output core_ctl_pkg::trap_ctl_t  trap_ctl_o
);
  import core_ctl_pkg::*;

  phase_e phase_q;
  logic   s0;
  logic   s1;
  logic   s2;
  logic   s3;
  logic   trap_entry;

  // One instruction every four cycles
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      phase_q <= PH_OPERAND;
    end else begin
      phase_q <= phase_e'(phase_q + 2'd1);
    end
  end

  assign phase_o = phase_q;

  assign s0 = (phase_q == PH_OPERAND);
  assign s1 = (phase_q == PH_READ);
  assign s2 = (phase_q == PH_EXEC);
  assign s3 = (phase_q == PH_FETCH_HI);

  // Trap on an undefined word or on a pending trap
  assign trap_entry = !defined_i || trap_i;

  always_comb begin
    fetch_ctl_o.adr_npc       = s1 || (s0 && !trap_entry);
    fetch_ctl_o.adr_npc_plus2 = s2 || s3;
    fetch_ctl_o.size_2        = 1'b1;  // Always halfword bus
    fetch_ctl_o.vpa           = 1'b1;
    fetch_ctl_o.we            = 1'b0;
    fetch_ctl_o.irl_dat       = s1 && ack_i;
    fetch_ctl_o.irh_dat       = s3 && ack_i;
    fetch_ctl_o.ir_dat_irl    = s3 && ack_i;
    fetch_ctl_o.cpc_npc       = s3 && ack_i;
    fetch_ctl_o.npc_npc_plus4 = s3 && ack_i;
  end

  always_comb begin
    trap_ctl_o.adr_mtvec = s0 && trap_entry;
    trap_ctl_o.npc_mtvec = s0 && trap_entry;
    trap_ctl_o.mepc_npc  = s0 && trap_i && defined_i;  // Resume after this insn
    trap_ctl_o.mepc_cpc  = s0 && !defined_i;           // Faulting insn itself
    trap_ctl_o.mpie_mie  = s0 && trap_entry;
    trap_ctl_o.mie_0     = s0 && trap_entry;
    trap_ctl_o.mcause_we = s0 && trap_entry;
  end

  property p_phase_step;
    @(posedge clk_i) disable iff (reset_i)
      !$past(reset_i) |-> (phase_q == phase_e'($past(phase_q) + 2'd1));
  endproperty
  a_phase_step: assert property (p_phase_step)
    else $error("phase did not advance by one");

  property p_trap_phase0;
    @(posedge clk_i) disable iff (reset_i)
      (phase_q != PH_OPERAND) |-> (trap_ctl_o == '0);
  endproperty
  a_trap_phase0: assert property (p_trap_phase0)
    else $error("trap strobe outside phase 0");

endmodule

/* verilog/alu_op_decoder.sv */
`timescale 1ns/1ns

module alu_op_decoder (
  input  rv_insn_pkg::opimm_op_e   op_i,
  input  logic                     word_form_i,
  input  core_ctl_pkg::phase_e     phase_i,
  output core_ctl_pkg::alu_ctl_t   alu_ctl_o,
  output core_ctl_pkg::reg_ctl_t   reg_ctl_o
);
  import rv_insn_pkg::*;
  import core_ctl_pkg::*;

  alu_ctl_t en;
  logic     valid;
  logic     is_shift;
  logic     s0;
  logic     s1;
  logic     s2;

  assign s0 = (phase_i == PH_OPERAND);
  assign s1 = (phase_i == PH_READ);
  assign s2 = (phase_i == PH_EXEC);

  assign valid    = (op_i != OP_NONE);
  assign is_shift = (op_i == OP_SLL) || (op_i == OP_SRL) || (op_i == OP_SRA);

  // Enables per operation before phase qualification
  always_comb begin
    en = '0;
    case (op_i)
      OP_ADD: en.sum_en = 1'b1;
      OP_SLT: begin
        en.invb_en = 1'b1;
        en.lts_en  = 1'b1;
        en.cflag_1 = 1'b1;  // a + ~b + 1
      end
      OP_SLTU: begin
        en.invb_en = 1'b1;
        en.ltu_en  = 1'b1;
        en.cflag_1 = 1'b1;
      end
      OP_XOR: en.xor_en = 1'b1;
      OP_OR: begin
        en.and_en = 1'b1;  // OR built as AND plus XOR
        en.xor_en = 1'b1;
      end
      OP_AND: en.and_en = 1'b1;
      OP_SLL: en.lsh_en = 1'b1;
      OP_SRL: en.rsh_en = 1'b1;
      OP_SRA: begin
        en.rsh_en  = 1'b1;
        en.cflag_1 = 1'b1;  // Sign fill
      end
      default: en = '0;
    endcase
    en.sx32_en = word_form_i;
  end

  assign alu_ctl_o = (valid && s2) ? en : '0;

  always_comb begin
    reg_ctl_o.alub_imm6i = valid && s0 && is_shift;
    reg_ctl_o.alub_imm12 = valid && s0 && !is_shift;
    reg_ctl_o.ra_ir1     = valid && s1;
    reg_ctl_o.ra_ird     = valid && s2;
    reg_ctl_o.alua_rf    = valid && s2;
    reg_ctl_o.rf_alu     = valid && s2;
    reg_ctl_o.rmask      = {4{valid && s2}};
  end

  always_comb begin
    assert (!(alu_ctl_o.lsh_en && alu_ctl_o.rsh_en))
      else $error("left and right shift enabled together");
  end

endmodule

/* verilog/opimm_decode_unit.sv */
`timescale 1ns/1ns

module opimm_decode_unit #(
  parameter bit RV64 = 1'b1
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  rv_insn_pkg::insn_word_u  ir_i,
  input  logic                     trap_i,
  input  logic                     ack_i,
  output core_ctl_pkg::phase_e     phase_o,
  output logic                     defined_o,
  output core_ctl_pkg::fetch_ctl_t fetch_ctl_o,
  output core_ctl_pkg::trap_ctl_t  trap_ctl_o,
  output core_ctl_pkg::alu_ctl_t   alu_ctl_o,
  output core_ctl_pkg::reg_ctl_t   reg_ctl_o
);
  import rv_insn_pkg::*;

  opimm_op_e op;
  logic      word_form;

  opimm_field_decoder #(
    .RV64(RV64)
  ) u_field_dec (
    .insn_i     (ir_i),
    .op_o       (op),
    .word_form_o(word_form),
    .defined_o  (defined_o)
  );

  opimm_sequencer u_seq (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .defined_i  (defined_o),
    .trap_i     (trap_i),
    .ack_i      (ack_i),
    .phase_o    (phase_o),
    .fetch_ctl_o(fetch_ctl_o),
    .trap_ctl_o (trap_ctl_o)
  );

  alu_op_decoder u_alu_dec (
    .op_i       (op),
    .word_form_i(word_form),
    .phase_i    (phase_o),
    .alu_ctl_o  (alu_ctl_o),
    .reg_ctl_o  (reg_ctl_o)
  );

endmodule

/* tests/tb_opimm_decode_unit.sv */
`timescale 1ns/1ns

module tb_opimm_decode_unit;
  import rv_insn_pkg::*;
  import core_ctl_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;  // Well above 29 insns of at most 8 cycles plus reset

  logic        clk_i;
  logic        reset_i;
  insn_word_u  ir_i;
  logic        trap_i;
  logic        ack_i;
  phase_e      phase_o;
  logic        defined_o;
  fetch_ctl_t  fetch_ctl_o;
  trap_ctl_t   trap_ctl_o;
  alu_ctl_t    alu_ctl_o;
  reg_ctl_t    reg_ctl_o;
  phase_e      exp_phase;
  logic [15:0] lfsr_q = 16'd18476;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;

  opimm_decode_unit #(.RV64(1'b1)) uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Expected phase counting 0 to 3 and around
  always @(posedge clk_i) begin
    exp_phase <= reset_i ? PH_OPERAND : phase_e'(exp_phase + 2'd1);
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11
  function automatic logic [31:0] rand_word();
    logic [31:0] v;
    for (int k = 0; k < 32; k++) begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Random rd, rs1 and immediate around the forced decode fields
  function automatic insn_word_u make_insn(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [5:0] f6, input logic b25);
    insn_word_u w;
    w = rand_word();
    w.itype.opcode = opc;
    w.itype.funct3 = f3;
    if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
      w.shift.funct6    = f6;
      w.shift.shamt6[5] = b25;
    end
    return w;
  endfunction

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
    $display("MISMATCH %s in phase %0d: got 0x%h, expected 0x%h", name, exp_phase, got, want);
    errors++;
  endtask

  task automatic check_phase(input string name, input phase_e got, input phase_e want);
    if (got !== want) mismatch(name, {30'd0, got}, {30'd0, want});
  endtask

  task automatic check_fetch(input string name, input fetch_ctl_t got, input fetch_ctl_t want);
    if (got !== want) mismatch(name, {22'd0, got}, {22'd0, want});
  endtask

  task automatic check_trap(input string name, input trap_ctl_t got, input trap_ctl_t want);
    if (got !== want) mismatch(name, {25'd0, got}, {25'd0, want});
  endtask

  task automatic check_alu(input string name, input alu_ctl_t got, input alu_ctl_t want);
    if (got !== want) mismatch(name, {22'd0, got}, {22'd0, want});
  endtask

  task automatic check_reg(input string name, input reg_ctl_t got, input reg_ctl_t want);
    if (got !== want) mismatch(name, {22'd0, got}, {22'd0, want});
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) mismatch(name, {31'd0, got}, {31'd0, want});
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s, %0d mismatches", name, errors - err0);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Expected outputs for the current phase and driven inputs
  task automatic check_outputs(input opimm_op_e op, input logic def);
    fetch_ctl_t f;
    trap_ctl_t  t;
    alu_ctl_t   a;
    reg_ctl_t   r;
    logic       te;
    logic       sh;
    logic       p0;
    logic       p1;
    logic       p2;
    logic       p3;
    p0 = (exp_phase == PH_OPERAND);
    p1 = (exp_phase == PH_READ);
    p2 = (exp_phase == PH_EXEC);
    p3 = (exp_phase == PH_FETCH_HI);
    te = !def || trap_i;
    sh = op inside {OP_SLL, OP_SRL, OP_SRA};
    f = '0;
    f.adr_npc       = p1 || (p0 && !te);
    f.adr_npc_plus2 = p2 || p3;
    f.size_2        = 1'b1;
    f.vpa           = 1'b1;
    f.irl_dat       = p1 && ack_i;
    {f.irh_dat, f.ir_dat_irl, f.cpc_npc, f.npc_npc_plus4} = {4{p3 && ack_i}};
    t = '0;
    if (p0 && te) begin
      {t.adr_mtvec, t.npc_mtvec, t.mpie_mie, t.mie_0, t.mcause_we} = 5'b11111;
      t.mepc_cpc = !def;
      t.mepc_npc = def;
    end
    a = '0;
    r = '0;
    if (op != OP_NONE) begin
      case (op)
        OP_ADD:  a.sum_en = 1'b1;
        OP_SLT:  {a.invb_en, a.lts_en, a.cflag_1} = 3'b111;
        OP_SLTU: {a.invb_en, a.ltu_en, a.cflag_1} = 3'b111;
        OP_XOR:  a.xor_en = 1'b1;
        OP_OR:   {a.and_en, a.xor_en} = 2'b11;
        OP_AND:  a.and_en = 1'b1;
        OP_SLL:  a.lsh_en = 1'b1;
        OP_SRL:  a.rsh_en = 1'b1;
        default: {a.rsh_en, a.cflag_1} = 2'b11;  // SRA
      endcase
      a.sx32_en = (ir_i.itype.opcode == OPC_OP_IMM_32);
      if (!p2) a = '0;
      r.alub_imm6i = p0 && sh;
      r.alub_imm12 = p0 && !sh;
      r.ra_ir1     = p1;
      {r.ra_ird, r.alua_rf, r.rf_alu} = {3{p2}};
      r.rmask      = {4{p2}};
    end
    check_phase("phase_o", phase_o, exp_phase);
    check_bit("defined_o", defined_o, def);
    check_fetch("fetch_ctl_o", fetch_ctl_o, f);
    check_trap("trap_ctl_o", trap_ctl_o, t);
    check_alu("alu_ctl_o", alu_ctl_o, a);
    check_reg("reg_ctl_o", reg_ctl_o, r);
  endtask

  // One instruction from phase 0 with ack_i given per phase
  task automatic run_insn(input insn_word_u w, input opimm_op_e op, input logic def,
                          input logic trap, input logic [3:0] ack_by_phase);
    do begin
      next_cycle();
    end while (exp_phase != PH_OPERAND);
    for (int c = 0; c < 4; c++) begin
      if (c > 0) next_cycle();
      ir_i   = w;
      trap_i = trap;
      ack_i  = ack_by_phase[c[1:0]];
      #1;
      check_outputs(op, def);
    end
  endtask

  task automatic test_phase_sequence();
    int err0;
    err0 = errors;
    for (int i = 0; i < 5; i++) begin
      if (i > 0) next_cycle();
      #1;
      check_phase("phase_o", phase_o, phase_e'(i[1:0]));
    end
    report_test("phase sequence after reset", err0);
  endtask

  task automatic test_operations();
    int         err0;
    opimm_op_e  op;
    logic [2:0] f3;
    logic [5:0] f6;
    logic [6:0] opc;
    err0 = errors;
    for (int form = 0; form < 2; form++) begin
      opc = (form == 1) ? OPC_OP_IMM_32 : OPC_OP_IMM;
      for (int k = 1; k < 10; k++) begin
        op = opimm_op_e'(k[3:0]);
        case (op)
          OP_ADD:  f3 = F3_ADD;
          OP_SLT:  f3 = F3_SLT;
          OP_SLTU: f3 = F3_SLTU;
          OP_XOR:  f3 = F3_XOR;
          OP_OR:   f3 = F3_OR;
          OP_AND:  f3 = F3_AND;
          OP_SLL:  f3 = F3_SLL;
          default: f3 = F3_SRL_SRA;
        endcase
        f6 = (op == OP_SRA) ? F6_SRA : F6_SRL;
        run_insn(make_insn(opc, f3, f6, (form == 0)), op, 1'b1, 1'b0, 4'b1111);
      end
    end
    report_test("operations in base and word form", err0);
  endtask

  task automatic test_fetch_strobes();
    int err0;
    err0 = errors;
    run_insn(make_insn(OPC_OP_IMM, F3_XOR, F6_SRL, 1'b0), OP_XOR, 1'b1, 1'b0, 4'b0000);
    run_insn(make_insn(OPC_OP_IMM, F3_OR, F6_SRL, 1'b0), OP_OR, 1'b1, 1'b0, 4'b0101);
    run_insn(make_insn(OPC_OP_IMM_32, F3_ADD, F6_SRL, 1'b0), OP_ADD, 1'b1, 1'b0, 4'b1010);
    report_test("fetch strobes gated by ack", err0);
  endtask

  task automatic test_trap_entry();
    int err0;
    err0 = errors;
    run_insn(make_insn(OPC_OP_IMM, F3_ADD, F6_SRL, 1'b0), OP_ADD, 1'b1, 1'b1, 4'b1111);
    run_insn(make_insn(7'b0000011, F3_ADD, F6_SRL, 1'b0), OP_NONE, 1'b0, 1'b0, 4'b1111);
    run_insn(make_insn(7'b0000011, F3_AND, F6_SRL, 1'b0), OP_NONE, 1'b0, 1'b1, 4'b1010);
    report_test("trap entry", err0);
  endtask

  task automatic test_undefined_words();
    int err0;
    err0 = errors;
    run_insn(make_insn(7'b0110011, F3_ADD, F6_SRL, 1'b0), OP_NONE, 1'b0, 1'b0, 4'b1111);
    run_insn(make_insn(OPC_OP_IMM, F3_SRL_SRA, 6'b100000, 1'b0), OP_NONE, 1'b0, 1'b0, 4'b1111);
    run_insn(make_insn(OPC_OP_IMM, F3_SLL, F6_SRA, 1'b0), OP_NONE, 1'b0, 1'b0, 4'b1111);
    run_insn(make_insn(OPC_OP_IMM_32, F3_SLL, F6_SRL, 1'b1), OP_NONE, 1'b0, 1'b0, 4'b1111);
    run_insn(make_insn(OPC_OP_IMM_32, F3_SRL_SRA, F6_SRA, 1'b1), OP_NONE, 1'b0, 1'b0, 4'b1111);
    report_test("undefined words", err0);
  endtask

  initial begin
    reset_i = 1'b1;
    ir_i    = '0;
    trap_i  = 1'b0;
    ack_i   = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    test_phase_sequence();
    test_operations();
    test_fetch_strobes();
    test_trap_entry();
    test_undefined_words();
    $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
    if (tests_failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* opimm_decode_unit.f */
verilog/rv_insn_pkg.sv
verilog/core_ctl_pkg.sv
verilog/opimm_field_decoder.sv
verilog/opimm_sequencer.sv
verilog/alu_op_decoder.sv
verilog/opimm_decode_unit.sv
tests/tb_opimm_decode_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_opimm_decode_unit \
  -f opimm_decode_unit.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
